// ==== team_04.f ====
logic/chip_pkg.sv
logic/link_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_decoder.sv
logic/wishbone_manager.sv
logic/team_04.sv
bench/tb_wb_memory.sv
bench/tb_team_04.sv

// ==== Makefile ====
# Verilator build and run for the team_04 serial to memory bridge

VERILATOR ?= verilator
TOP       ?= tb_team_04
FILELIST  ?= team_04.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Everything OK

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_team_04.sv ====
// testbench for the team_04 serial to memory bridge
// random write and burst read frames over the UART pins,
// reference memory model, bus cycle and pin checks

`timescale 1ns/1ps

module tb_team_04
    import chip_pkg::*;
    import link_pkg::*;
();

    localparam int          CLKS_PER_BIT   = 8;
    localparam int          N_CMDS         = 60;
    localparam logic [31:0] SEED           = 32'he38f_3311;
    // worst case every command is a full burst, plus bus waits and the en phase
    localparam int          TIMEOUT_CYCLES = N_CMDS * (2 + 4 * 16) * 10 * CLKS_PER_BIT + 20000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        en;
    logic [33:0] gpio_in;
    logic [33:0] gpio_out;
    logic [33:0] gpio_oeb;
    wb_adr_t     mem_adr_start;
    wb_adr_t     wb_adr;
    wb_dat_t     wb_dat_w;
    wb_sel_t     wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    wb_dat_t     wb_dat_r;
    logic        wb_ack;
    logic        acc_valid;
    wb_adr_t     acc_adr;
    logic        acc_we;
    logic        acc_in_window;

    logic [31:0] rng_state;
    wb_dat_t     model [0:2047];
    wb_adr_t     exp_adr_q[$];
    logic        exp_we_q[$];
    logic [7:0]  reply_q[$];
    int          cycles = 0;

    always #4 clk = ~clk;

    team_04 #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (
        .clk(clk), .rst_n(rst_n), .en(en),
        .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oeb(gpio_oeb),
        .mem_adr_start(mem_adr_start),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_we(wb_we),
        .wb_stb(wb_stb), .wb_cyc(wb_cyc), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    tb_wb_memory #(.SEED(SEED)) u_mem (
        .clk(clk), .rst_n(rst_n), .base(mem_adr_start),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_we(wb_we),
        .wb_stb(wb_stb), .wb_cyc(wb_cyc), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .acc_valid(acc_valid), .acc_adr(acc_adr), .acc_we(acc_we),
        .acc_in_window(acc_in_window)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_word(input string name, input wb_dat_t exp, input wb_dat_t act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_adr(input string name, input wb_adr_t exp, input wb_adr_t act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_pins(input string name, input logic [33:0] exp, input logic [33:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // host side 8N1, start bit first then lsb first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            gpio_in[5] <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // four reply bytes, msb first
    task automatic get_reply_word(output wb_dat_t w);
        w = '0;
        for (int k = 0; k < 4; k++) begin
            while (reply_q.size() == 0) @(negedge clk);
            w = {w[23:0], reply_q.pop_front()};
        end
    endtask

    task automatic run_write(input logic [OFFSET_W-1:0] off, input wb_sel_t sel,
                             input wb_dat_t data);
        cmd_header_u hdr;
        hdr.wr.op     = OP_WRITE;
        hdr.wr.sel    = sel;
        hdr.wr.offset = off;
        // only the selected lanes change
        for (int k = 0; k < 4; k++) begin
            if (sel[k]) model[off][8*k +: 8] = data[8*k +: 8];
        end
        exp_adr_q.push_back(mem_adr_start + (wb_adr_t'(off) << 2));
        exp_we_q.push_back(1'b1);
        send_byte(hdr[15:8]);
        send_byte(hdr[7:0]);
        for (int k = 3; k >= 0; k--) send_byte(data[8*k +: 8]);
    endtask

    task automatic run_read(input logic [OFFSET_W-1:0] off, input logic [3:0] burst);
        cmd_header_u         hdr;
        wb_dat_t             got;
        logic [OFFSET_W-1:0] o;
        hdr.rd.op     = OP_READ;
        hdr.rd.burst  = burst;
        hdr.rd.offset = off;
        // consecutive offsets, wrapping in 11 bits
        o = off;
        for (int k = 0; k <= int'(burst); k++) begin
            exp_adr_q.push_back(mem_adr_start + (wb_adr_t'(o) << 2));
            exp_we_q.push_back(1'b0);
            o = o + 1'b1;
        end
        send_byte(hdr[15:8]);
        send_byte(hdr[7:0]);
        o = off;
        for (int k = 0; k <= int'(burst); k++) begin
            get_reply_word(got);
            check_word("reply word", model[o], got);
            o = o + 1'b1;
        end
    endtask

    // reply line monitor, sampled mid-bit on falling edges
    always begin
        logic [7:0] b;
        @(negedge clk);
        if (rst_n && en && !gpio_out[0]) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_bit("gpio_out[0] start bit", 1'b0, gpio_out[0]);
            for (int k = 0; k < 8; k++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[k] = gpio_out[0];
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_bit("gpio_out[0] stop bit", 1'b1, gpio_out[0]);
            reply_q.push_back(b);
        end
    end

    // every finished bus cycle against the expected order
    always @(negedge clk) begin
        if (acc_valid) begin
            if (exp_adr_q.size() == 0) begin
                $display("unexpected Wishbone cycle at %0t to address %h", $time, acc_adr);
                $display("Something failed");
                $fatal(1);
            end else begin
                check_bit("wb_adr inside memory window", 1'b1, acc_in_window);
                check_adr("wb_adr", exp_adr_q.pop_front(), acc_adr);
                check_bit("wb_we", exp_we_q.pop_front(), acc_we);
            end
        end
    end

    // disabled chip releases its pins and stays off the bus
    always @(negedge clk) begin
        if (rst_n && !en) begin
            check_bit("wb_cyc", 1'b0, wb_cyc);
            check_pins("gpio_out", '0, gpio_out);
            check_pins("gpio_oeb", '1, gpio_oeb);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run hung", cycles);
            $display("Something failed");
            $fatal(1);
        end
    end

    initial begin
        logic [31:0]         r;
        logic [OFFSET_W-1:0] off;
        logic [OFFSET_W-1:0] last_off;
        rng_state  = SEED;
        rst_n      = 1'b0;
        en         = 1'b1;
        gpio_in    = '0;
        gpio_in[5] = 1'b1;
        last_off   = '0;
        // random nonzero word-aligned base
        r             = next_rand();
        mem_adr_start = {r[31:2], 2'b00};
        if (mem_adr_start == '0) mem_adr_start = 32'h0000_1000;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 2048; i++) model[i] = u_mem.mem[i];
        @(negedge clk);
        check_bit("wb_cyc", 1'b0, wb_cyc);
        check_bit("wb_stb", 1'b0, wb_stb);
        check_bit("wb_we", 1'b0, wb_we);
        check_bit("gpio_out[0]", 1'b1, gpio_out[0]);
        check_bit("gpio_oeb[0]", 1'b0, gpio_oeb[0]);

        // write, read back the same offset, then a burst
        for (int i = 0; i < N_CMDS; i++) begin
            r = next_rand();
            case (i % 3)
                0: begin
                    last_off = r[10:0];
                    run_write(last_off, r[14:11], next_rand());
                end
                1: run_read(last_off, 4'd0);
                default: begin
                    // top of the offset range half the time, to wrap
                    off = r[16] ? {8'hff, r[2:0]} : r[10:0];
                    run_read(off, r[20:17]);
                end
            endcase
        end

        // write frame while disabled, completes after en returns
        r = next_rand();
        @(posedge clk);
        en <= 1'b0;
        run_write(r[10:0], r[14:11], next_rand());
        repeat (40) @(posedge clk);
        en <= 1'b1;
        run_read(r[10:0], 4'd0);

        repeat (4 * CLKS_PER_BIT) @(posedge clk);
        if (exp_adr_q.size() != 0 || reply_q.size() != 0) begin
            $display("bus cycles or reply bytes left over at the end of the run");
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== bench/tb_wb_memory.sv ====
// Wishbone slave memory for the testbench
// 2048 words above a base address, acknowledges after a random delay
// and reports every finished cycle with an address window check

`timescale 1ns/1ps

module tb_wb_memory
    import chip_pkg::*;
#(
    parameter logic [31:0] SEED = 32'he38f_3311
) (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_adr_t base,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_dat_w,
    input  wb_sel_t wb_sel,
    input  logic    wb_we,
    input  logic    wb_stb,
    input  logic    wb_cyc,
    output wb_dat_t wb_dat_r,
    output logic    wb_ack,
    output logic    acc_valid,
    output wb_adr_t acc_adr,
    output logic    acc_we,
    output logic    acc_in_window
);

    wb_dat_t     mem [0:2047];
    logic [31:0] rng_state;
    logic        pending;
    logic [1:0]  wait_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fill depends on every index bit
    initial begin
        rng_state     = SEED;
        wb_ack        = 1'b0;
        wb_dat_r      = '0;
        acc_valid     = 1'b0;
        acc_adr       = '0;
        acc_we        = 1'b0;
        acc_in_window = 1'b0;
        pending       = 1'b0;
        wait_cnt      = '0;
        for (int i = 0; i < 2048; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h6d2b_79f5;
        end
    end

    always @(posedge clk) begin
        wb_adr_t     rel;
        wb_dat_t     merged;
        logic [10:0] idx;
        int          k;
        // word index relative to the window base
        rel       = wb_adr - base;
        idx       = rel[12:2];
        acc_valid <= 1'b0;
        if (!rst_n) begin
            wb_ack  <= 1'b0;
            pending <= 1'b0;
        end else if (wb_ack) begin
            // single-cycle acknowledge
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!pending) begin
                // extra wait of 0 to 3 cycles
                rng_state = xorshift32(rng_state);
                pending  <= 1'b1;
                wait_cnt <= rng_state[1:0];
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                pending       <= 1'b0;
                wb_ack        <= 1'b1;
                acc_valid     <= 1'b1;
                acc_adr       <= wb_adr;
                acc_we        <= wb_we;
                acc_in_window <= (rel[1:0] == 2'b00) && (rel < 32'd8192);
                if (wb_we) begin
                    merged = mem[idx];
                    for (k = 0; k < 4; k++) begin
                        if (wb_sel[k]) merged[8*k +: 8] = wb_dat_w[8*k +: 8];
                    end
                    mem[idx] <= merged;
                end else begin
                    wb_dat_r <= mem[idx];
                end
            end
        end
    end

endmodule

// ==== logic/team_04.sv ====
// team 04 chip top, serial to memory bridge
// UART command path on the GPIO pins, Wishbone manager to external memory
// offsets are relocated by mem_adr_start, everything holds while en is low

`timescale 1ns/1ps

module team_04
    import chip_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic [33:0] gpio_in,
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb,
    input  wb_adr_t     mem_adr_start,
    output wb_adr_t     wb_adr,
    output wb_dat_t     wb_dat_w,
    output wb_sel_t     wb_sel,
    output logic        wb_we,
    output logic        wb_stb,
    output logic        wb_cyc,
    input  wb_dat_t     wb_dat_r,
    input  logic        wb_ack
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] tx_byte;
    logic       tx_valid;
    logic       tx_ready;
    logic       tx_line;

    logic       mem_read;
    logic       mem_write;
    wb_adr_t    dec_adr;
    wb_adr_t    mem_adr;
    wb_sel_t    mem_sel;
    wb_dat_t    mem_wdata;
    wb_dat_t    mem_rdata;
    logic       mgr_busy;

    // design offset relocated into the memory window
    assign mem_adr = dec_adr + mem_adr_start;

    // host receive pin
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (gpio_in[5]),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    // disabled chip looks permanently busy to the decoder
    cmd_decoder u_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .tx_byte   (tx_byte),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_adr   (dec_adr),
        .mem_sel   (mem_sel),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_busy  (mgr_busy | !en)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (tx_line)
    );

    wishbone_manager u_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_busy  (mgr_busy),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_we     (wb_we),
        .wb_stb    (wb_stb),
        .wb_cyc    (wb_cyc),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    // pins default to inputs driven low
    always_comb begin
        gpio_out = '0;
        gpio_oeb = '1;
        if (en) begin
            // reply line on pin 0
            gpio_out[0] = tx_line;
            gpio_oeb[0] = 1'b0;
        end
    end

endmodule

// ==== logic/wishbone_manager.sv ====
// Wishbone classic master
// turns one-cycle read/write pulses from the user logic into a bus cycle
// and reports busy until the acknowledge has been taken

`timescale 1ns/1ps

module wishbone_manager
    import chip_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    mem_read,
    input  logic    mem_write,
    input  wb_adr_t mem_adr,
    input  wb_sel_t mem_sel,
    input  wb_dat_t mem_wdata,
    output wb_dat_t mem_rdata,
    output logic    mem_busy,
    output wb_adr_t wb_adr,
    output wb_dat_t wb_dat_w,
    output wb_sel_t wb_sel,
    output logic    wb_we,
    output logic    wb_stb,
    output logic    wb_cyc,
    input  wb_dat_t wb_dat_r,
    input  logic    wb_ack
);

    logic start;
    logic done;

    // a new request is only taken between bus cycles
    assign start = (mem_read || mem_write) && !wb_cyc;
    assign done  = wb_cyc && wb_ack;

    // busy window is exactly the bus cycle
    // up one cycle after the request, down one cycle after ack
    assign mem_busy = wb_cyc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else if (start) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= mem_write;
        end else if (done) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
    end

    // address, data and lanes held for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= mem_adr;
            wb_dat_w <= mem_wdata;
            wb_sel   <= mem_sel;
        end
    end

    // read word stays put until the next read completes
    always_ff @(posedge clk) begin
        if (done && !wb_we) begin
            mem_rdata <= wb_dat_r;
        end
    end

    a_stb_in_cyc: assert property (
        @(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc
    );

    // slave may stall for any number of cycles
    a_adr_stable: assert property (
        @(posedge clk) disable iff (!rst_n) (wb_stb && !wb_ack) |=> $stable(wb_adr)
    );

endmodule

// ==== logic/cmd_decoder.sv ====
// command decoder and sequencer
// assembles host frames, issues word writes and read bursts,
// and streams read words back msb first as reply bytes

`timescale 1ns/1ps

module cmd_decoder
    import chip_pkg::*;
    import link_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    output logic [7:0] tx_byte,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic       mem_read,
    output logic       mem_write,
    output wb_adr_t    mem_adr,
    output wb_sel_t    mem_sel,
    output wb_dat_t    mem_wdata,
    input  wb_dat_t    mem_rdata,
    input  logic       mem_busy
);

    typedef enum logic [2:0] {HEAD, DATA, WRITE, RD_REQ, RD_WAIT, RD_SEND} state_t;

    state_t              state_q;
    logic [1:0]          byte_cnt;
    logic [7:0]          hdr_hi;
    cmd_header_u         hdr_in;
    cmd_header_u         hdr_q;
    logic [OFFSET_W-1:0] offset_q;
    logic [3:0]          words_left;
    wb_dat_t             wdata_q;
    wb_dat_t             word_q;

    // full header as it completes with the second byte
    assign hdr_in = cmd_header_u'({hdr_hi, rx_byte});

    // requests are single-cycle and only while the bus side is free
    assign mem_write = (state_q == WRITE) && !mem_busy;
    assign mem_read  = (state_q == RD_REQ) && !mem_busy;
    // word offset to byte offset
    assign mem_adr   = {{(WB_ADR_W - OFFSET_W - 2){1'b0}}, offset_q, 2'b00};
    // reads always fetch the whole word
    assign mem_sel   = (state_q == WRITE) ? hdr_q.wr.sel : '1;
    assign mem_wdata = wdata_q;

    // reply bytes come from the top of the captured word
    assign tx_valid = (state_q == RD_SEND);
    assign tx_byte  = word_q[WB_DAT_W-1 -: 8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= HEAD;
            byte_cnt <= '0;
        end else begin
            case (state_q)
                HEAD: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd1) begin
                            byte_cnt <= '0;
                            case (hdr_in.wr.op)
                                OP_WRITE: state_q <= DATA;
                                OP_READ:  state_q <= RD_REQ;
                            endcase
                        end
                    end
                end
                // counter wraps back to zero after four data bytes
                DATA: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            state_q <= WRITE;
                        end
                    end
                end
                WRITE: if (!mem_busy) state_q <= HEAD;
                RD_REQ: if (!mem_busy) state_q <= RD_WAIT;
                // busy is already up on the cycle after the request
                RD_WAIT: if (!mem_busy) state_q <= RD_SEND;
                RD_SEND: begin
                    if (tx_ready) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            state_q <= (words_left == 4'd0) ? HEAD : RD_REQ;
                        end
                    end
                end
                default: state_q <= HEAD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            HEAD: begin
                if (rx_valid && byte_cnt == 2'd0) begin
                    hdr_hi <= rx_byte;
                end
                if (rx_valid && byte_cnt == 2'd1) begin
                    hdr_q      <= hdr_in;
                    // offset sits in the same bits in both views
                    offset_q   <= hdr_in.rd.offset;
                    words_left <= hdr_in.rd.burst;
                end
            end
            DATA: if (rx_valid) wdata_q <= {wdata_q[WB_DAT_W-9:0], rx_byte};
            RD_WAIT: if (!mem_busy) word_q <= mem_rdata;
            RD_SEND: begin
                if (tx_ready) begin
                    word_q <= {word_q[WB_DAT_W-9:0], 8'h00};
                    // offset of the next burst word wraps in 11 bits
                    if (byte_cnt == 2'd3) begin
                        offset_q   <= offset_q + 1'b1;
                        words_left <= words_left - 1'b1;
                    end
                end
            end
            default: ;
        endcase
    end

    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) (mem_read || mem_write) |-> !mem_busy
    );

endmodule

// ==== logic/uart_tx.sv ====
// UART transmitter, 8N1
// takes a byte on a ready/valid handshake and shifts out start, data, stop

`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(CLKS_PER_BIT - 1);

    // stop, data, start with the start bit at the bottom
    logic [9:0]       frame_q;
    logic [CNT_W-1:0] cnt_q;
    logic [3:0]       bit_idx;
    logic             busy_q;

    assign tx_ready = !busy_q;
    // line follows bit 0, all ones once the frame has shifted out
    assign tx       = frame_q[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            frame_q <= '1;
            cnt_q   <= '0;
            bit_idx <= '0;
        end else if (!busy_q) begin
            if (tx_valid) begin
                frame_q <= {1'b1, tx_byte, 1'b0};
                busy_q  <= 1'b1;
                cnt_q   <= '0;
                bit_idx <= '0;
            end
        end else if (cnt_q == FULL_LAST) begin
            cnt_q   <= '0;
            // shift in ones so the line returns to idle
            frame_q <= {1'b1, frame_q[9:1]};
            bit_idx <= bit_idx + 1'b1;
            // ten bit times after acceptance
            if (bit_idx == 4'd9) begin
                busy_q <= 1'b0;
            end
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // idle line must sit at the mark level between frames
    a_tx_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n) tx_ready |-> tx
    );

endmodule

// ==== logic/uart_rx.sv ====
// UART receiver, 8N1
// samples the line at mid-bit and hands out one byte per good frame
// frames with a low stop bit are discarded

`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    // last count of a full bit and of half a bit
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t           state_q;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    // byte is read straight from the shift register
    assign rx_byte = shift_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state_q  <= IDLE;
            cnt_q    <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            // two-flop synchronizer, line idles high
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    // falling edge marks a start bit
                    if (!rx_sync) begin
                        state_q <= START;
                    end
                end
                START: begin
                    if (cnt_q == HALF_LAST) begin
                        cnt_q   <= '0;
                        bit_idx <= '0;
                        // glitch shorter than half a bit
                        state_q <= rx_sync ? IDLE : DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                DATA: begin
                    if (cnt_q == FULL_LAST) begin
                        cnt_q   <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state_q <= STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                STOP: begin
                    if (cnt_q == FULL_LAST) begin
                        // only a high stop bit delivers the byte
                        rx_valid <= rx_sync;
                        state_q  <= IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state_q == DATA && cnt_q == FULL_LAST) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    // decoder has no back-pressure, so every byte is a single strobe
    a_rx_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
    );

endmodule

// ==== logic/link_pkg.sv ====
// serial link protocol definitions
// opcodes and the 16-bit command header shared by host and decoder

package link_pkg;

    // word offset carried in every header
    localparam int OFFSET_W = 11;

    // top bit of the header selects the view
    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    // write header, byte lanes to replace
    typedef struct packed {
        logic                op;
        logic [3:0]          sel;
        logic [OFFSET_W-1:0] offset;
    } wr_header_t;

    // read header, burst is word count minus one
    typedef struct packed {
        logic                op;
        logic [3:0]          burst;
        logic [OFFSET_W-1:0] offset;
    } rd_header_t;

    // same header word, decoded by its opcode bit
    typedef union packed {
        wr_header_t wr;
        rd_header_t rd;
    } cmd_header_u;

endpackage

// ==== logic/chip_pkg.sv ====
// chip bus definitions
// widths and word types of the Wishbone port to external memory

package chip_pkg;

    // byte address and data word widths
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;

    // one select bit per byte lane
    localparam int WB_SEL_W = WB_DAT_W / 8;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;
    typedef logic [WB_SEL_W-1:0] wb_sel_t;

endpackage
